// ==== fpga_pkg.sv ====
// board widths, synchronizer depth, debounce defaults, ICAP command words, sequencer states

package fpga_pkg;

    // push buttons and LEDs
    localparam int BTN_W = 4;

    // flops per synchronizer chain
    localparam int SYNC_STAGES = 2;

    // agreeing samples the debouncer needs, and cycles between samples
    localparam int DEBOUNCE_N = 4;
    // 1 ms at 125 MHz
    localparam int DEBOUNCE_RATE = 125000;

    // configuration port data width
    localparam int ICAP_W = 32;

    // reboot command words in configuration port bit order
    // before the per-byte reversal
    localparam logic [ICAP_W-1:0] ICAP_DUMMY = 32'hFFFF_FFFF;
    localparam logic [ICAP_W-1:0] ICAP_SYNC = 32'hAA99_5566;
    // type 1 no-op packet
    localparam logic [ICAP_W-1:0] ICAP_NOOP = 32'h2000_0000;
    // type 1 write of one word to the CMD register
    localparam logic [ICAP_W-1:0] ICAP_WR_CMD = 32'h3000_8001;
    // IPROG command, triggers the warm boot
    localparam logic [ICAP_W-1:0] ICAP_IPROG = 32'h0000_000F;

    // sequencer states named after the word on the port in that state
    // the closing no-op goes out while the FSM is back in idle
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_DUMMY  = 3'd1,
        ST_SYNC   = 3'd2,
        ST_NOOP   = 3'd3,
        ST_WR_CMD = 3'd4,
        ST_IPROG  = 3'd5
    } icap_state_t;

endpackage

// ==== sync_signal.sv ====
// multi-bit, multi-stage synchronizer for asynchronous inputs

`timescale 1ns/100ps

module sync_signal import fpga_pkg::*; #(
    parameter int WIDTH = 1,
    parameter int N = SYNC_STAGES
) (
    input  wire logic             clk_125mhz_int,
    input  wire logic             rst_n,
    input  wire logic [WIDTH-1:0] in_sig,
    output wire logic [WIDTH-1:0] out_sig
);

    // stage 0 samples the pin, stage N-1 is the synchronized copy
    logic [N-1:0][WIDTH-1:0] sync_reg;

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            sync_reg <= '0;
        end else begin
            sync_reg[0] <= in_sig;
            for (int k = 1; k < N; k++) begin
                sync_reg[k] <= sync_reg[k-1];
            end
        end
    end

    // exactly N cycles from pin to output
    assign out_sig = sync_reg[N-1];

endmodule

// ==== debounce_switch.sv ====
// switch debouncer with a shared sample tick and per-bit sample history

`timescale 1ns/100ps

module debounce_switch import fpga_pkg::*; #(
    parameter int WIDTH = BTN_W,
    parameter int N = DEBOUNCE_N,
    parameter int RATE = DEBOUNCE_RATE
) (
    input  wire logic             clk_125mhz_int,
    input  wire logic             rst_n,
    input  wire logic [WIDTH-1:0] in_sig,
    output wire logic [WIDTH-1:0] out_sig
);

    // wide enough to hold RATE-1
    localparam int CNT_W = $clog2(RATE + 1);

    logic [CNT_W-1:0] cnt_reg;
    logic             sample_tick;

    // one tick every RATE cycles, first one RATE cycles after reset
    assign sample_tick = (cnt_reg == CNT_W'(RATE - 1));

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            cnt_reg <= '0;
        end else if (sample_tick) begin
            cnt_reg <= '0;
        end else begin
            cnt_reg <= cnt_reg + 1'b1;
        end
    end

    for (genvar i = 0; i < WIDTH; i++) begin : g_bit

        logic [N-1:0] hist_reg;
        logic [N-1:0] hist_next;
        logic         state_reg;

        // newest sample enters at bit 0
        assign hist_next = {hist_reg[N-2:0], in_sig[i]};

        always_ff @(posedge clk_125mhz_int) begin
            if (!rst_n) begin
                hist_reg <= '0;
                state_reg <= 1'b0;
            end else if (sample_tick) begin
                hist_reg <= hist_next;
                // decide on the history including this sample,
                // so the output moves on the completing tick
                if (&hist_next) begin
                    state_reg <= 1'b1;
                end else if (~|hist_next) begin
                    state_reg <= 1'b0;
                end
                // mixed history keeps the old level
            end
        end

        assign out_sig[i] = state_reg;

    end

endmodule

// ==== icap_reboot.sv ====
// ICAP reboot sequencer writing the IPROG command sequence to the configuration port

`timescale 1ns/100ps

module icap_reboot import fpga_pkg::*; (
    input  wire logic              clk_125mhz_int,
    input  wire logic              rst_n,
    input  wire logic              boot_req,
    input  wire logic              avail,
    output wire logic              csib,
    output wire logic              rdwrb,
    output wire logic [ICAP_W-1:0] di
);

    icap_state_t       state_reg;
    logic              csib_reg;
    logic [ICAP_W-1:0] word_reg;

    // port sequence is dummy, sync, no-op, write CMD, IPROG, no-op
    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n) begin
            state_reg <= ST_IDLE;
            csib_reg <= 1'b1;
            word_reg <= ICAP_DUMMY;
        end else begin
            case (state_reg)
                ST_IDLE: begin
                    csib_reg <= 1'b1;
                    word_reg <= ICAP_DUMMY;
                    // avail only matters when starting a sequence
                    if (boot_req && avail) begin
                        state_reg <= ST_DUMMY;
                        csib_reg <= 1'b0;
                    end
                end
                ST_DUMMY: begin
                    state_reg <= ST_SYNC;
                    csib_reg <= 1'b0;
                    word_reg <= ICAP_SYNC;
                end
                ST_SYNC: begin
                    state_reg <= ST_NOOP;
                    csib_reg <= 1'b0;
                    word_reg <= ICAP_NOOP;
                end
                ST_NOOP: begin
                    state_reg <= ST_WR_CMD;
                    csib_reg <= 1'b0;
                    word_reg <= ICAP_WR_CMD;
                end
                ST_WR_CMD: begin
                    state_reg <= ST_IPROG;
                    csib_reg <= 1'b0;
                    word_reg <= ICAP_IPROG;
                end
                ST_IPROG: begin
                    // closing no-op goes out from idle,
                    // a held request restarts right after it
                    state_reg <= ST_IDLE;
                    csib_reg <= 1'b0;
                    word_reg <= ICAP_NOOP;
                end
                default: begin
                    state_reg <= ST_IDLE;
                    csib_reg <= 1'b1;
                    word_reg <= ICAP_DUMMY;
                end
            endcase
        end
    end

    // the port takes each byte MSB first on bit 0
    for (genvar b = 0; b < ICAP_W / 8; b++) begin : g_byte
        for (genvar i = 0; i < 8; i++) begin : g_bit
            assign di[b*8 + i] = word_reg[b*8 + 7 - i];
        end
    end

    assign csib = csib_reg;
    // the sequencer only writes, never a readback
    assign rdwrb = 1'b0;

endmodule

// ==== fpga_top.sv ====
// board top level with input synchronizers, button debouncer and ICAP reboot sequencer

`timescale 1ns/100ps

module fpga_top import fpga_pkg::*; #(
    // shortened in simulation
    parameter int DEBOUNCE_RATE = fpga_pkg::DEBOUNCE_RATE
) (
    input  wire logic              clk_125mhz_int,
    input  wire logic              rst_n,

    // buttons and LEDs
    input  wire logic [BTN_W-1:0]  btn,
    output wire logic [BTN_W-1:0]  led,

    // asynchronous reboot request level
    input  wire logic              fpga_boot,

    // configuration port
    input  wire logic              icap_avail,
    output wire logic              icap_csib,
    output wire logic              icap_rdwrb,
    output wire logic [ICAP_W-1:0] icap_di
);

    logic [BTN_W-1:0] btn_sync;
    logic             fpga_boot_sync;

    // buttons are synchronized, then debounced straight onto the LEDs
    sync_signal #(
        .WIDTH(BTN_W),
        .N(SYNC_STAGES)
    ) btn_sync_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n(rst_n),
        .in_sig(btn),
        .out_sig(btn_sync)
    );

    debounce_switch #(
        .WIDTH(BTN_W),
        .N(DEBOUNCE_N),
        .RATE(DEBOUNCE_RATE)
    ) debounce_switch_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n(rst_n),
        .in_sig(btn_sync),
        .out_sig(led)
    );

    // boot request crosses in through its own single-bit chain
    sync_signal #(
        .WIDTH(1),
        .N(SYNC_STAGES)
    ) fpga_boot_sync_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n(rst_n),
        .in_sig(fpga_boot),
        .out_sig(fpga_boot_sync)
    );

    // icap_avail is already in this clock domain
    icap_reboot icap_reboot_inst (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n(rst_n),
        .boot_req(fpga_boot_sync),
        .avail(icap_avail),
        .csib(icap_csib),
        .rdwrb(icap_rdwrb),
        .di(icap_di)
    );

endmodule

// ==== tb_fpga.sv ====
// testbench for fpga_top with debounce and reboot sequence reference models

`timescale 1ns/100ps

module tb_fpga import fpga_pkg::*; ();

    // short sample period so the debouncer moves within a few dozen cycles
    localparam int TB_RATE = 8;
    localparam int DEB_PATTERNS = 80;
    localparam int DEB_HOLD_MAX = TB_RATE * (DEBOUNCE_N + 2);
    localparam int BB_CYCLES = 60;

    // planned stimulus length per phase in clock cycles
    localparam int RST_CYCLES = 2;
    localparam int DEB_CYCLES = DEB_PATTERNS * DEB_HOLD_MAX;
    localparam int ONE_SEQ_CYCLES = 40;
    localparam int BLOCKED_CYCLES = 80;
    localparam int B2B_CYCLES = BB_CYCLES + 30;
    localparam int PLAN_CYCLES = RST_CYCLES + DEB_CYCLES + ONE_SEQ_CYCLES
                                 + BLOCKED_CYCLES + B2B_CYCLES;
    localparam int CYCLE_LIMIT = 2 * PLAN_CYCLES;

    logic              clk_125mhz_int = 1'b0;
    logic              rst_n;
    logic [BTN_W-1:0]  btn;
    logic              fpga_boot;
    logic              icap_avail;
    logic [BTN_W-1:0]  led;
    logic              icap_csib;
    logic              icap_rdwrb;
    logic [ICAP_W-1:0] icap_di;

    integer seed;
    int     cycle_cnt = 0;
    int     dut_starts = 0;
    int     model_starts = 0;
    int     led_changes = 0;
    logic [BTN_W-1:0] led_prev = '0;

    // reference model state
    logic [SYNC_STAGES-1:0][BTN_W-1:0] btn_pipe;
    logic [SYNC_STAGES-1:0]            boot_pipe;
    int                                tick_cnt;
    logic [DEBOUNCE_N-1:0]             hist [BTN_W];
    logic [BTN_W-1:0]                  exp_led;
    icap_state_t                       exp_st;
    // closing no-op sent while the sequencer is already idle
    logic                              exp_close;

    fpga_top #(
        .DEBOUNCE_RATE(TB_RATE)
    ) dut0 (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n(rst_n),
        .btn(btn),
        .led(led),
        .fpga_boot(fpga_boot),
        .icap_avail(icap_avail),
        .icap_csib(icap_csib),
        .icap_rdwrb(icap_rdwrb),
        .icap_di(icap_di)
    );

    always #4 clk_125mhz_int = ~clk_125mhz_int;

    always @(posedge clk_125mhz_int) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on failure");
    endtask

    task automatic check_value(input string name, input logic [ICAP_W-1:0] actual,
                               input logic [ICAP_W-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERR time=%0t signal=%s actual=%h expected=%h",
                               $time, name, actual, expected));
        end
    endtask

    // every byte of the word with its bit order flipped
    function automatic logic [ICAP_W-1:0] reverse_bytes(input logic [ICAP_W-1:0] w);
        logic [ICAP_W-1:0] r;
        for (int b = 0; b < ICAP_W / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                r[b*8 + i] = w[b*8 + 7 - i];
            end
        end
        return r;
    endfunction

    // k-th word of the reboot sequence before reversal
    function automatic logic [ICAP_W-1:0] seq_word(input int k);
        case (k)
            0: return ICAP_DUMMY;
            1: return ICAP_SYNC;
            2: return ICAP_NOOP;
            3: return ICAP_WR_CMD;
            4: return ICAP_IPROG;
            default: return ICAP_NOOP;
        endcase
    endfunction

    function automatic logic [ICAP_W-1:0] expected_word();
        if (exp_close) begin
            return ICAP_NOOP;
        end
        case (exp_st)
            ST_SYNC: return ICAP_SYNC;
            ST_NOOP: return ICAP_NOOP;
            ST_WR_CMD: return ICAP_WR_CMD;
            ST_IPROG: return ICAP_IPROG;
            default: return ICAP_DUMMY;
        endcase
    endfunction

    function automatic logic expected_csib();
        return (exp_st == ST_IDLE) && !exp_close;
    endfunction

    // advance the models by the rising edge that has just passed
    task automatic model_step();
        logic [BTN_W-1:0]      btn_in;
        logic                  boot_in;
        logic [DEBOUNCE_N-1:0] h;
        btn_in = btn_pipe[SYNC_STAGES-1];
        boot_in = boot_pipe[SYNC_STAGES-1];
        if (!rst_n) begin
            btn_pipe = '0;
            boot_pipe = '0;
            tick_cnt = 0;
            exp_led = '0;
            for (int i = 0; i < BTN_W; i++) begin
                hist[i] = '0;
            end
            exp_st = ST_IDLE;
            exp_close = 1'b0;
        end else begin
            // debouncer samples every TB_RATE cycles and moves only on a unanimous history
            if (tick_cnt == TB_RATE - 1) begin
                tick_cnt = 0;
                for (int i = 0; i < BTN_W; i++) begin
                    h = {hist[i][DEBOUNCE_N-2:0], btn_in[i]};
                    hist[i] = h;
                    if (h == '1) begin
                        exp_led[i] = 1'b1;
                    end else if (h == '0) begin
                        exp_led[i] = 1'b0;
                    end
                end
            end else begin
                tick_cnt++;
            end
            // sequencer
            case (exp_st)
                ST_IDLE: begin
                    exp_close = 1'b0;
                    if (boot_in && icap_avail) begin
                        exp_st = ST_DUMMY;
                        model_starts++;
                    end
                end
                ST_DUMMY: exp_st = ST_SYNC;
                ST_SYNC: exp_st = ST_NOOP;
                ST_NOOP: exp_st = ST_WR_CMD;
                ST_WR_CMD: exp_st = ST_IPROG;
                default: begin
                    exp_st = ST_IDLE;
                    exp_close = 1'b1;
                end
            endcase
            // input synchronizer chains
            for (int k = SYNC_STAGES - 1; k > 0; k--) begin
                btn_pipe[k] = btn_pipe[k-1];
                boot_pipe[k] = boot_pipe[k-1];
            end
            btn_pipe[0] = btn;
            boot_pipe[0] = fpga_boot;
        end
    endtask

    // one clock cycle with model update and full output compare at the falling edge
    task automatic step();
        @(negedge clk_125mhz_int);
        model_step();
        check_value("led", ICAP_W'(led), ICAP_W'(exp_led));
        check_value("icap_csib", ICAP_W'(icap_csib), ICAP_W'(expected_csib()));
        check_value("icap_rdwrb", ICAP_W'(icap_rdwrb), '0);
        check_value("icap_di", icap_di, reverse_bytes(expected_word()));
        if (icap_csib == 1'b0 && icap_di == reverse_bytes(ICAP_DUMMY)) begin
            dut_starts++;
        end
        if (led != led_prev) begin
            led_changes++;
        end
        led_prev = led;
    endtask

    task automatic wait_for_start(input int max_cycles);
        int n;
        n = 0;
        while (icap_csib !== 1'b0) begin
            if (n >= max_cycles) begin
                fail_run($sformatf("no reboot sequence started within %0d cycles", max_cycles));
            end else begin
                step();
                n++;
            end
        end
    endtask

    // current cycle carries the dummy word, five more words follow
    task automatic check_sequence();
        for (int k = 0; k < 6; k++) begin
            if (k > 0) begin
                step();
            end
            check_value("icap_csib", ICAP_W'(icap_csib), '0);
            check_value("icap_rdwrb", ICAP_W'(icap_rdwrb), '0);
            check_value("icap_di", icap_di, reverse_bytes(seq_word(k)));
        end
        step();
        check_value("icap_csib", ICAP_W'(icap_csib), ICAP_W'(1'b1));
    endtask

    initial begin
        int hold;
        int starts0;
        int models0;
        int gap;
        seed = 32'h8f1be1b4;
        rst_n = 1'b0;
        btn = '0;
        fpga_boot = 1'b0;
        icap_avail = 1'b0;

        // reset state
        repeat (RST_CYCLES) step();
        check_value("icap_csib", ICAP_W'(icap_csib), ICAP_W'(1'b1));
        check_value("icap_rdwrb", ICAP_W'(icap_rdwrb), '0);
        check_value("icap_di", icap_di, reverse_bytes(ICAP_DUMMY));
        check_value("led", ICAP_W'(led), '0);
        rst_n = 1'b1;

        // random button patterns with every fourth one long enough to settle
        for (int p = 0; p < DEB_PATTERNS; p++) begin
            btn = BTN_W'($random(seed));
            icap_avail = 1'($random(seed));
            if (p % 4 == 3) begin
                hold = TB_RATE * (DEBOUNCE_N + 1);
            end else begin
                hold = 1 + ({$random(seed)} % DEB_HOLD_MAX);
            end
            repeat (hold) step();
        end
        if (led_changes == 0) begin
            fail_run("led never changed during the debounce test");
        end

        // single boot pulse with the port available
        starts0 = dut_starts;
        fpga_boot = 1'b1;
        icap_avail = 1'b1;
        step();
        fpga_boot = 1'b0;
        wait_for_start(10);
        check_sequence();
        repeat (20) step();
        check_value("sequence_count", ICAP_W'(dut_starts - starts0), ICAP_W'(1));

        // request held while the port is busy
        starts0 = dut_starts;
        fpga_boot = 1'b1;
        icap_avail = 1'b0;
        repeat (40) begin
            step();
            check_value("icap_csib", ICAP_W'(icap_csib), ICAP_W'(1'b1));
        end
        fpga_boot = 1'b0;
        icap_avail = 1'b1;
        wait_for_start(10);
        check_sequence();
        repeat (20) step();
        check_value("sequence_count", ICAP_W'(dut_starts - starts0), ICAP_W'(1));

        // held request gives back-to-back sequences
        starts0 = dut_starts;
        models0 = model_starts;
        fpga_boot = 1'b1;
        icap_avail = 1'b1;
        wait_for_start(10);
        gap = 0;
        repeat (BB_CYCLES) begin
            step();
            if (icap_csib) begin
                gap++;
            end else begin
                gap = 0;
            end
            if (gap > 1) begin
                fail_run("more than one idle cycle between back-to-back sequences");
            end
        end
        fpga_boot = 1'b0;
        repeat (20) step();
        check_value("icap_csib", ICAP_W'(icap_csib), ICAP_W'(1'b1));
        if (dut_starts - starts0 < 3) begin
            fail_run("held boot request did not repeat the reboot sequence");
        end
        check_value("sequence_count", ICAP_W'(dut_starts - starts0),
                    ICAP_W'(model_starts - models0));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
fpga_pkg.sv
sync_signal.sv
debounce_switch.sv
icap_reboot.sv
fpga_top.sv
tb_fpga.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fpga_top testbench with Verilator.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=tb_fpga_sim

verilator --binary --timing \
    --timescale 1ns/100ps \
    -Wno-fatal \
    --top-module tb_fpga \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_EXE" \
    -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
